// File: sim.f
+incdir+.
glbl_pkg.sv
glbl_bus_fsm.sv
glbl_lfsr.sv
glbl_cfg_regs.sv
glbl_intr_ctrl.sv
glbl_reg_top.sv
tb_glbl_reg.sv

// File: tb_glbl_reg.sv
// Self-checking testbench for the global register block. Drives the cs/ack
// bus, keeps a register and generator model and compares every read.

`default_nettype none

`include "glbl_config.svh"

module tb_glbl_reg;

   localparam int ACK_LIMIT = 8;
   // About 60 accesses of 3 cycles plus interrupt waits with a tenfold margin
   localparam int WATCHDOG_TIME = 20000;

   logic                 mclk;
   logic                 s_reset_n;
   logic                 reg_cs;
   glbl_pkg::glbl_req_t  reg_req;
   glbl_pkg::glbl_word_t reg_rdata;
   logic                 reg_ack;
   glbl_pkg::glbl_irq_t  hw_intr;
   glbl_pkg::glbl_irq_t  irq_lines;
   logic                 soft_irq;
   logic [2:0]           user_irq;
   glbl_pkg::glbl_rst_t  periph_rst_n;

   // Register model indexed by address
   glbl_pkg::glbl_word_t model_regs [32];
   glbl_pkg::glbl_addr_t rw_addrs [5];
   int                   ack_count;
   int                   check_count;
   int                   error_count;
   glbl_pkg::glbl_word_t rd1;
   glbl_pkg::glbl_word_t rd2;
   glbl_pkg::glbl_word_t rnd_exp;
   // Pending checks for the compare process
   string                name_q [$];
   glbl_pkg::glbl_word_t exp_q [$];
   glbl_pkg::glbl_word_t act_q [$];

   glbl_reg_top dut_i (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_cs       (reg_cs),
      .reg_req      (reg_req),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack),
      .hw_intr      (hw_intr),
      .irq_lines    (irq_lines),
      .soft_irq     (soft_irq),
      .user_irq     (user_irq),
      .periph_rst_n (periph_rst_n)
   );

   initial begin
      mclk = 1'b0;
      forever #5 mclk = ~mclk;
   end

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   // Galois step with taps folded in on a dropped one
   function automatic glbl_pkg::glbl_word_t lfsr_next(input glbl_pkg::glbl_word_t v);
      return v[0] ? ((v >> 1) ^ `GLBL_LFSR_TAPS) : (v >> 1);
   endfunction

   function automatic glbl_pkg::glbl_word_t lfsr_after(input int steps);
      glbl_pkg::glbl_word_t v;
      v = `GLBL_LFSR_SEED;
      for (int i = 0; i < steps; i++) begin
         v = lfsr_next(v);
      end
      return v;
   endfunction

   function automatic glbl_pkg::glbl_word_t byte_merge(input glbl_pkg::glbl_word_t old,
      input glbl_pkg::glbl_word_t data, input glbl_pkg::glbl_be_t be);
      glbl_pkg::glbl_word_t res;
      res = old;
      for (int b = 0; b < `GLBL_BE_W; b++) begin
         if (be[b]) res[8*b +: 8] = data[8*b +: 8];
      end
      return res;
   endfunction

   // Expected read data before this access lands
   function automatic glbl_pkg::glbl_word_t read_model(input glbl_pkg::glbl_addr_t addr);
      if (addr == `GLBL_ADDR_RAND) return lfsr_after(ack_count);
      if (addr == `GLBL_ADDR_SET) return model_regs[`GLBL_ADDR_STAT];
      return model_regs[addr];
   endfunction

   task automatic model_write(input glbl_pkg::glbl_addr_t addr,
      input glbl_pkg::glbl_word_t data, input glbl_pkg::glbl_be_t be);
      case (addr)
         `GLBL_ADDR_RST, `GLBL_ADDR_CFG, `GLBL_ADDR_MBOX, `GLBL_ADDR_SCR0,
         `GLBL_ADDR_SCR1, `GLBL_ADDR_SCR2, `GLBL_ADDR_SCR3:
            model_regs[addr] = byte_merge(model_regs[addr], data, be);
         // Interrupt registers hold 16 bits
         `GLBL_ADDR_MASK: model_regs[addr] = byte_merge(model_regs[addr], data, be) & 32'hFFFF;
         `GLBL_ADDR_STAT: model_regs[addr] &= ~(byte_merge('0, data, be) & 32'hFFFF);
         `GLBL_ADDR_SET:  model_regs[`GLBL_ADDR_STAT] |= byte_merge('0, data, be) & 32'hFFFF;
         default: ;
      endcase
   endtask

   // ------------------------------------------------------------
   // Bus tasks entered 1 unit after a rising edge
   // ------------------------------------------------------------
   task automatic expect_value(input string name, input glbl_pkg::glbl_word_t exp,
      input glbl_pkg::glbl_word_t act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
   endtask

   task automatic bus_access(input logic wr, input glbl_pkg::glbl_addr_t addr,
      input glbl_pkg::glbl_word_t wdata, input glbl_pkg::glbl_be_t be,
      output glbl_pkg::glbl_word_t rdata);
      int waited;
      waited        = 0;
      reg_req.wr    = wr;
      reg_req.addr  = addr;
      reg_req.wdata = wdata;
      reg_req.be    = be;
      reg_cs        = 1'b1;
      @(posedge mclk);
      #1;
      while (!reg_ack && waited < ACK_LIMIT) begin
         @(posedge mclk);
         #1;
         waited++;
      end
      rdata = reg_rdata;
      if (!reg_ack) begin
         error_count++;
         $display("Bus access to address %0d got no acknowledge", addr);
      end else begin
         ack_count++;
         if (wr) model_write(addr, wdata, be);
      end
      // Drop cs in the cycle after ack and idle one cycle
      @(posedge mclk);
      #1;
      reg_cs  = 1'b0;
      reg_req = '0;
      @(posedge mclk);
      #1;
   endtask

   task automatic check_read(input string name, input glbl_pkg::glbl_addr_t addr);
      glbl_pkg::glbl_word_t exp;
      glbl_pkg::glbl_word_t act;
      exp = read_model(addr);
      bus_access(1'b0, addr, '0, '0, act);
      expect_value(name, exp, act);
   endtask

   // ------------------------------------------------------------
   // Compare process
   // ------------------------------------------------------------
   initial begin : compare_proc
      string                name;
      glbl_pkg::glbl_word_t exp;
      glbl_pkg::glbl_word_t act;
      forever begin
         wait (act_q.size() != 0);
         name = name_q.pop_front();
         exp  = exp_q.pop_front();
         act  = act_q.pop_front();
         check_count++;
         if (act !== exp) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
         end
      end
   end

   initial begin
      #WATCHDOG_TIME;
      $display("Watchdog expired before the tests finished");
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("Simulation FAILED");
      $finish;
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      void'($urandom(1));
      s_reset_n   = 1'b0;
      reg_cs      = 1'b0;
      reg_req     = '0;
      hw_intr     = '0;
      ack_count   = 0;
      check_count = 0;
      error_count = 0;
      rw_addrs    = '{`GLBL_ADDR_MBOX, `GLBL_ADDR_SCR0, `GLBL_ADDR_SCR1,
                      `GLBL_ADDR_SCR2, `GLBL_ADDR_SCR3};
      model_regs  = '{default: '0};
      model_regs[`GLBL_ADDR_ID]  = `GLBL_CHIP_ID;
      model_regs[`GLBL_ADDR_RST] = `GLBL_RST_CTRL_DEF;
      repeat (3) @(posedge mclk);
      #1;
      s_reset_n = 1'b1;

      // Reset values
      expect_value("reset periph_rst_n", `GLBL_RST_CTRL_DEF & 32'hFF, periph_rst_n);
      expect_value("reset irq_lines", '0, irq_lines);
      expect_value("reset soft/user irq", '0, {soft_irq, user_irq});
      expect_value("reset reg_rdata", '0, reg_rdata);
      check_read("reset id", `GLBL_ADDR_ID);
      check_read("reset rst ctrl", `GLBL_ADDR_RST);
      for (int i = 0; i < 5; i++) check_read("reset mbox/scratch", rw_addrs[i]);

      // Byte-enabled random writes
      for (int n = 0; n < 12; n++) begin
         bus_access(1'b1, rw_addrs[$urandom % 5], $urandom,
                    glbl_pkg::glbl_be_t'($urandom), rd1);
      end
      for (int i = 0; i < 5; i++) check_read("merged mbox/scratch", rw_addrs[i]);
      bus_access(1'b1, `GLBL_ADDR_RST, $urandom, 4'b0001, rd1);
      expect_value("periph_rst_n", model_regs[`GLBL_ADDR_RST] & 32'hFF, periph_rst_n);
      bus_access(1'b1, `GLBL_ADDR_ID, $urandom, 4'b1111, rd1);
      check_read("id after write", `GLBL_ADDR_ID);
      for (int a = 12; a < 32; a++) begin
         check_read($sformatf("unmapped %0d", a), glbl_pkg::glbl_addr_t'(a));
      end

      // Hardware interrupts with bit 9 left masked
      bus_access(1'b1, `GLBL_ADDR_MASK, 32'h0000_0024, 4'b0001, rd1);
      hw_intr = 16'h0220;
      repeat (4) @(posedge mclk);
      #1;
      hw_intr = '0;
      repeat (6) @(posedge mclk);
      #1;
      model_regs[`GLBL_ADDR_STAT] |= 32'h0220;
      check_read("hw status", `GLBL_ADDR_STAT);
      expect_value("hw irq_lines",
         model_regs[`GLBL_ADDR_STAT] & model_regs[`GLBL_ADDR_MASK], irq_lines);
      bus_access(1'b1, `GLBL_ADDR_STAT, 32'h0000_0220, 4'b0011, rd1);
      check_read("status after clear", `GLBL_ADDR_STAT);
      expect_value("irq_lines after clear", '0, irq_lines);

      // Software set through byte 1 only and config outputs
      bus_access(1'b1, `GLBL_ADDR_SET, 32'h0000_8181, 4'b0010, rd1);
      check_read("set readback", `GLBL_ADDR_SET);
      check_read("status after set", `GLBL_ADDR_STAT);
      bus_access(1'b1, `GLBL_ADDR_MASK, 32'h0000_FFFF, 4'b0011, rd1);
      expect_value("irq_lines after set", model_regs[`GLBL_ADDR_STAT], irq_lines);
      bus_access(1'b1, `GLBL_ADDR_CFG, 32'h0000_000D, 4'b0001, rd1);
      expect_value("soft_irq", model_regs[`GLBL_ADDR_CFG][3], soft_irq);
      expect_value("user_irq", model_regs[`GLBL_ADDR_CFG][2:0], user_irq);

      // Generator follows the acknowledge count
      check_read("random by count", `GLBL_ADDR_RAND);
      rnd_exp = lfsr_after(ack_count);
      bus_access(1'b0, `GLBL_ADDR_RAND, '0, '0, rd1);
      bus_access(1'b0, `GLBL_ADDR_RAND, '0, '0, rd2);
      expect_value("random first read", rnd_exp, rd1);
      expect_value("random single step", lfsr_next(rnd_exp), rd2);
      check_read("random after steps", `GLBL_ADDR_RAND);

      #1;
      wait (act_q.size() == 0);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: glbl_reg_top.sv
// Top of the global register block. Ties the bus sequencer, the random
// generator and the two register blocks together behind one cs/ack bus.

`default_nettype none

module glbl_reg_top (
   input  logic                  mclk,
   input  logic                  s_reset_n,
   // Register bus
   input  logic                  reg_cs,
   input  glbl_pkg::glbl_req_t   reg_req,
   output glbl_pkg::glbl_word_t  reg_rdata,
   output logic                  reg_ack,
   // Interrupts
   input  glbl_pkg::glbl_irq_t   hw_intr,
   output glbl_pkg::glbl_irq_t   irq_lines,
   output logic                  soft_irq,
   output logic [2:0]            user_irq,
   // Peripheral resets, active low
   output glbl_pkg::glbl_rst_t   periph_rst_n
);

   glbl_pkg::glbl_word_t cfg_rd_word;
   glbl_pkg::glbl_word_t intr_rd_word;
   glbl_pkg::glbl_word_t random;
   logic                 wr_stb;
   logic                 ack_stb;

   // ------------------------------------------------------------
   // Bus sequencer
   // ------------------------------------------------------------
   glbl_bus_fsm bus_fsm_i (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_cs       (reg_cs),
      .reg_req      (reg_req),
      .cfg_rd_word  (cfg_rd_word),
      .intr_rd_word (intr_rd_word),
      .reg_rdata    (reg_rdata),
      .reg_ack      (reg_ack),
      .wr_stb       (wr_stb),
      .ack_stb      (ack_stb)
   );

   // Steps once per completed access
   glbl_lfsr lfsr_i (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .ack_stb   (ack_stb),
      .random    (random)
   );

   // ------------------------------------------------------------
   // Register blocks
   // ------------------------------------------------------------
   glbl_cfg_regs cfg_regs_i (
      .mclk         (mclk),
      .s_reset_n    (s_reset_n),
      .reg_req      (reg_req),
      .wr_stb       (wr_stb),
      .random       (random),
      .rd_word      (cfg_rd_word),
      .periph_rst_n (periph_rst_n),
      .soft_irq     (soft_irq),
      .user_irq     (user_irq)
   );

   glbl_intr_ctrl intr_ctrl_i (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .reg_req   (reg_req),
      .wr_stb    (wr_stb),
      .hw_intr   (hw_intr),
      .rd_word   (intr_rd_word),
      .irq_lines (irq_lines)
   );

endmodule

`default_nettype wire

// File: glbl_intr_ctrl.sv
// Interrupt mask and status. Hardware requests pass a two-flop
// synchronizer; software clears status by writing ones and can raise
// status bits through the set address.

`default_nettype none

`include "glbl_config.svh"

module glbl_intr_ctrl (
   input  logic                  mclk,
   input  logic                  s_reset_n,
   input  glbl_pkg::glbl_req_t   reg_req,
   input  logic                  wr_stb,
   input  glbl_pkg::glbl_irq_t   hw_intr,
   output glbl_pkg::glbl_word_t  rd_word,
   output glbl_pkg::glbl_irq_t   irq_lines
);

   glbl_pkg::glbl_irq_t sync1_q;
   glbl_pkg::glbl_irq_t sync2_q;
   glbl_pkg::glbl_irq_t mask_q;
   glbl_pkg::glbl_irq_t stat_q;
   glbl_pkg::glbl_irq_t wmask;
   glbl_pkg::glbl_irq_t wbits;
   glbl_pkg::glbl_irq_t sw_set;
   glbl_pkg::glbl_irq_t sw_clr;

   // Low bytes of the write with enables applied
   assign wmask = glbl_pkg::glbl_irq_t'(glbl_pkg::be_mask(reg_req.be));
   assign wbits = reg_req.wdata[`GLBL_IRQ_W-1:0] & wmask;

   assign sw_set = (wr_stb && reg_req.addr == `GLBL_ADDR_SET)  ? wbits : '0;
   assign sw_clr = (wr_stb && reg_req.addr == `GLBL_ADDR_STAT) ? wbits : '0;

   // ------------------------------------------------------------
   // Request synchronizer
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= hw_intr;
         sync2_q <= sync1_q;
      end
   end

   // ------------------------------------------------------------
   // Mask and status
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         mask_q <= '0;
         stat_q <= '0;
      end else begin
         if (wr_stb && reg_req.addr == `GLBL_ADDR_MASK) begin
            mask_q <= (mask_q & ~wmask) | wbits;
         end
         // Set beats clear on the same bit
         stat_q <= (stat_q & ~sw_clr) | sync2_q | sw_set;
      end
   end

   // ------------------------------------------------------------
   // Read decode
   // ------------------------------------------------------------
   always_comb begin
      case (reg_req.addr)
         `GLBL_ADDR_MASK: rd_word = glbl_pkg::glbl_word_t'(mask_q);
         // Set address reads back status
         `GLBL_ADDR_STAT,
         `GLBL_ADDR_SET:  rd_word = glbl_pkg::glbl_word_t'(stat_q);
         default:         rd_word = '0;
      endcase
   end

   // Pending and enabled
   assign irq_lines = stat_q & mask_q;

endmodule

`default_nettype wire

// File: glbl_cfg_regs.sv
// Identification, peripheral reset control, configuration, mailbox,
// scratch and random readback registers. Returns zero for addresses
// that belong to another block.

`default_nettype none

`include "glbl_config.svh"

module glbl_cfg_regs (
   input  logic                  mclk,
   input  logic                  s_reset_n,
   input  glbl_pkg::glbl_req_t   reg_req,
   input  logic                  wr_stb,
   input  glbl_pkg::glbl_word_t  random,
   output glbl_pkg::glbl_word_t  rd_word,
   output glbl_pkg::glbl_rst_t   periph_rst_n,
   output logic                  soft_irq,
   output logic [2:0]            user_irq
);

   glbl_pkg::glbl_word_t rst_ctrl_q;
   glbl_pkg::glbl_word_t cfg_q;
   glbl_pkg::glbl_word_t mbox_q;
   glbl_pkg::glbl_word_t scr_q [4];
   glbl_pkg::glbl_word_t wmask;

   assign wmask = glbl_pkg::be_mask(reg_req.be);

   // Byte-enabled merge of write data into an old value
   function automatic glbl_pkg::glbl_word_t merge(input glbl_pkg::glbl_word_t old);
      return (old & ~wmask) | (reg_req.wdata & wmask);
   endfunction

   // ------------------------------------------------------------
   // Writable registers
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl_q <= `GLBL_RST_CTRL_DEF;
         cfg_q      <= '0;
         mbox_q     <= '0;
         for (int i = 0; i < 4; i++) begin
            scr_q[i] <= '0;
         end
      end else if (wr_stb) begin
         // ID and random are read-only, writes there drop
         case (reg_req.addr)
            `GLBL_ADDR_RST:  rst_ctrl_q <= merge(rst_ctrl_q);
            `GLBL_ADDR_CFG:  cfg_q      <= merge(cfg_q);
            `GLBL_ADDR_MBOX: mbox_q     <= merge(mbox_q);
            `GLBL_ADDR_SCR0: scr_q[0]   <= merge(scr_q[0]);
            `GLBL_ADDR_SCR1: scr_q[1]   <= merge(scr_q[1]);
            `GLBL_ADDR_SCR2: scr_q[2]   <= merge(scr_q[2]);
            `GLBL_ADDR_SCR3: scr_q[3]   <= merge(scr_q[3]);
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Read decode
   // ------------------------------------------------------------
   always_comb begin
      case (reg_req.addr)
         `GLBL_ADDR_ID:   rd_word = `GLBL_CHIP_ID;
         `GLBL_ADDR_RST:  rd_word = rst_ctrl_q;
         `GLBL_ADDR_CFG:  rd_word = cfg_q;
         `GLBL_ADDR_MBOX: rd_word = mbox_q;
         `GLBL_ADDR_RAND: rd_word = random;
         `GLBL_ADDR_SCR0: rd_word = scr_q[0];
         `GLBL_ADDR_SCR1: rd_word = scr_q[1];
         `GLBL_ADDR_SCR2: rd_word = scr_q[2];
         `GLBL_ADDR_SCR3: rd_word = scr_q[3];
         // Interrupt block and unmapped space
         default:         rd_word = '0;
      endcase
   end

   // Peripheral resets, active low
   assign periph_rst_n = rst_ctrl_q[`GLBL_RST_W-1:0];

   // CPU interrupt requests from config
   assign soft_irq = cfg_q[3];
   assign user_irq = cfg_q[2:0];

endmodule

`default_nettype wire

// File: glbl_lfsr.sv
// Pseudorandom word for the random register. A 32-bit Galois LFSR that
// steps once per bus acknowledge, so its value follows bus traffic.

`default_nettype none

`include "glbl_config.svh"

module glbl_lfsr (
   input  logic                  mclk,
   input  logic                  s_reset_n,
   input  logic                  ack_stb,
   output glbl_pkg::glbl_word_t  random
);

   glbl_pkg::glbl_word_t lfsr_q;
   glbl_pkg::glbl_word_t lfsr_d;

   // ------------------------------------------------------------
   // One Galois step
   // ------------------------------------------------------------
   always_comb begin
      // Shift right, fold taps in when a one drops out
      lfsr_d = lfsr_q >> 1;
      if (lfsr_q[0]) begin
         lfsr_d = lfsr_d ^ `GLBL_LFSR_TAPS;
      end
   end

   // Seed must be nonzero or the sequence locks up
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         lfsr_q <= `GLBL_LFSR_SEED;
      end else if (ack_stb) begin
         lfsr_q <= lfsr_d;
      end
   end

   // Readback sees the value before this access's step
   assign random = lfsr_q;

endmodule

`default_nettype wire

// File: glbl_bus_fsm.sv
// Register bus access sequencer. Answers every chip select in one cycle,
// registers the combined read word and strobes writes and the generator.

`default_nettype none

module glbl_bus_fsm (
   input  logic                  mclk,
   input  logic                  s_reset_n,
   input  logic                  reg_cs,
   input  glbl_pkg::glbl_req_t   reg_req,
   input  glbl_pkg::glbl_word_t  cfg_rd_word,
   input  glbl_pkg::glbl_word_t  intr_rd_word,
   output glbl_pkg::glbl_word_t  reg_rdata,
   output logic                  reg_ack,
   output logic                  wr_stb,
   output logic                  ack_stb
);

   glbl_pkg::glbl_bus_state_t state_q;
   glbl_pkg::glbl_bus_state_t state_d;

   // ------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         glbl_pkg::BUS_IDLE: begin
            if (reg_cs) begin
               state_d = glbl_pkg::BUS_ACK;
            end
         end
         // Ack lasts one cycle only
         glbl_pkg::BUS_ACK: state_d = glbl_pkg::BUS_IDLE;
         default:           state_d = glbl_pkg::BUS_IDLE;
      endcase
   end

   // ------------------------------------------------------------
   // State and read data registers
   // ------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         state_q   <= glbl_pkg::BUS_IDLE;
         reg_rdata <= '0;
      end else begin
         state_q <= state_d;
         // Sample before any write of this access lands
         if (state_q == glbl_pkg::BUS_IDLE && reg_cs) begin
            reg_rdata <= cfg_rd_word | intr_rd_word;
         end
      end
   end

   // Strobes decoded from state
   assign reg_ack = (state_q == glbl_pkg::BUS_ACK);
   assign ack_stb = (state_q == glbl_pkg::BUS_ACK);
   // Write lands on the edge closing the ack cycle
   assign wr_stb  = (state_q == glbl_pkg::BUS_ACK) && reg_req.wr;

endmodule

`default_nettype wire

// File: glbl_pkg.sv
// Shared types of the global register block. Every RTL file and the
// testbench refer to these by scoped names.

`default_nettype none

`include "glbl_config.svh"

package glbl_pkg;

   // ------------------------------------------------------------
   // Vector types
   // ------------------------------------------------------------
   typedef logic [`GLBL_DATA_W-1:0] glbl_word_t;
   typedef logic [`GLBL_ADDR_W-1:0] glbl_addr_t;
   typedef logic [`GLBL_BE_W-1:0]   glbl_be_t;
   typedef logic [`GLBL_IRQ_W-1:0]  glbl_irq_t;
   typedef logic [`GLBL_RST_W-1:0]  glbl_rst_t;

   // One bus request, held by the master until ack
   typedef struct packed {
      logic       wr;
      glbl_addr_t addr;
      glbl_word_t wdata;
      glbl_be_t   be;
   } glbl_req_t;

   // Access sequencer states
   typedef enum logic {
      BUS_IDLE,
      BUS_ACK
   } glbl_bus_state_t;

   // Byte enables widened to a bit mask
   function automatic glbl_word_t be_mask(input glbl_be_t be);
      glbl_word_t mask;
      for (int i = 0; i < `GLBL_BE_W; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

// File: glbl_config.svh
// Widths, register map, reset values and generator constants of the global
// register block. Included by the package and by every module that decodes
// addresses or loads a constant.

`ifndef GLBL_CONFIG_SVH
`define GLBL_CONFIG_SVH

// Bus and vector widths
`define GLBL_DATA_W        32
`define GLBL_ADDR_W        5
`define GLBL_BE_W          4
`define GLBL_IRQ_W         16
`define GLBL_RST_W         8

// Constants and reset values
`define GLBL_CHIP_ID       32'h4D43_0101
// Lowest two peripherals leave reset by default
`define GLBL_RST_CTRL_DEF  32'h0000_0003
`define GLBL_LFSR_SEED     32'hACE1_5EED
// Galois mask for x^32 + x^22 + x^2 + x + 1
`define GLBL_LFSR_TAPS     32'h8020_0003

// Register map
`define GLBL_ADDR_ID       5'd0
`define GLBL_ADDR_RST      5'd1
`define GLBL_ADDR_CFG      5'd2
`define GLBL_ADDR_MASK     5'd3
`define GLBL_ADDR_STAT     5'd4
`define GLBL_ADDR_MBOX     5'd5
`define GLBL_ADDR_RAND     5'd6
`define GLBL_ADDR_SET      5'd7
`define GLBL_ADDR_SCR0     5'd8
`define GLBL_ADDR_SCR1     5'd9
`define GLBL_ADDR_SCR2     5'd10
`define GLBL_ADDR_SCR3     5'd11

`endif
